// ==== sources.f ====
+incdir+verification
logic/rlbp_pkg.sv
logic/rlbp_wb_regs.sv
logic/rlbp_frame_counter.sv
logic/rlbp_window_channel.sv
logic/rlbp_timing_top.sv
verification/rlbp_timing_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = rlbp_timing_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = tests failed
PASS_MSG = all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/rlbp_tb_tasks.svh ====
// rlbp timing testbench helpers
// wishbone master cycles, typed result compares and the stimulus LCG
`ifndef RLBP_TB_TASKS_SVH
`define RLBP_TB_TASKS_SVH

logic [31:0] lcg_state = 32'd92047;

// plain 32-bit LCG
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

task automatic abort_run();
    $display("tests failed");
    $fatal(1);
endtask

task automatic check_word(input logic [WB_DATA_W-1:0] got, input logic [WB_DATA_W-1:0] exp,
        input string what);
    if (got !== exp) begin
        $display("Mismatch at %0d ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_count(input logic [TIME_W-1:0] got, input logic [TIME_W-1:0] exp,
        input string what);
    if (got !== exp) begin
        $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

// one wishbone access that drops stb in the cycle it sees ack
task automatic bus_cycle(input logic write, input logic [3:0] sel,
        input logic [WB_DATA_W-1:0] adr, input logic [WB_DATA_W-1:0] wdata,
        output logic [WB_DATA_W-1:0] rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = write;
    wb_sel   = sel;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack && waited < ACK_WAIT) begin
        @(negedge clk);
        waited++;
    end
    if (!wb_ack) begin
        $display("no ack within %0d cycles for address 0x%08h", ACK_WAIT, adr);
        abort_run();
    end
    rdata  = wb_dat_r;  // registered with the ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic wb_write(input logic [WB_DATA_W-1:0] adr, input logic [WB_DATA_W-1:0] data,
        input logic [3:0] sel);
    logic [WB_DATA_W-1:0] unused_rd;
    bus_cycle(1'b1, sel, adr, data, unused_rd);
endtask

task automatic wb_read(input logic [WB_DATA_W-1:0] adr, output logic [WB_DATA_W-1:0] data);
    bus_cycle(1'b0, 4'hF, adr, '0, data);
endtask

`endif

// ==== verification/rlbp_timing_tb.sv ====
`timescale 1ns/1ps
// rlbp timing core testbench
// register checks, then a table of strobe windows applied in a loop

module rlbp_timing_tb
    import rlbp_pkg::*;
();

    localparam int TIME_W       = TIME_W_DEFAULT;
    localparam int NUM_ROWS     = 8;
    localparam int ACK_WAIT     = 4;
    localparam int RESET_WATCH  = 64;   // quiet strobe cycles after reset
    localparam int SETUP_CYCLES = 400;  // reset and register phases
    localparam logic [WB_DATA_W-1:0] TIME_MASK = WB_DATA_W'((1 << TIME_W) - 1);

    logic                 clk;
    logic                 rst;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [3:0]           wb_sel;
    logic [WB_DATA_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic                 wb_ack;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic [NUM_CH-1:0]    strobes;  // indexed like the package channels

    // stimulus table, expected values filled by add_row
    int                row_ch       [NUM_ROWS];
    logic [TIME_W-1:0] row_up       [NUM_ROWS];
    logic [TIME_W-1:0] row_down     [NUM_ROWS];
    logic [TIME_W-1:0] row_period   [NUM_ROWS];
    logic [TIME_W-1:0] row_exp_high [NUM_ROWS];
    logic [TIME_W-1:0] row_exp_gap  [NUM_ROWS];
    int                row_count   = 0;
    int                cycle_count = 0;
    int                cycle_limit = 0;

    `include "rlbp_tb_tasks.svh"

    rlbp_timing_top #(
        .TIME_W (TIME_W)
    ) u_rlbp_timing_top (
        .clk           (clk),
        .rst           (rst),
        .wbs_cyc_i     (wb_cyc),
        .wbs_stb_i     (wb_stb),
        .wbs_we_i      (wb_we),
        .wbs_sel_i     (wb_sel),
        .wbs_adr_i     (wb_adr),
        .wbs_dat_i     (wb_dat_w),
        .wbs_ack_o     (wb_ack),
        .wbs_dat_o     (wb_dat_r),
        .vd1_o         (strobes[CH_VD1]),
        .vd2_o         (strobes[CH_VD2]),
        .sw1_o         (strobes[CH_SW1]),
        .sw2_o         (strobes[CH_SW2]),
        .sh_o          (strobes[CH_SH]),
        .sh_cmp_o      (strobes[CH_SH_CMP]),
        .sh_rst_o      (strobes[CH_SH_RST]),
        .counter_rst_o (strobes[CH_CNT_RST])
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("run passed its limit of %0d cycles", cycle_limit);
            abort_run();
        end
    end

    function automatic logic [WB_DATA_W-1:0] reg_addr(input logic [WB_DATA_W-1:0] offset);
        return {REGION_ID, offset[WB_DATA_W-5:0]};
    endfunction

    function automatic logic [WB_DATA_W-1:0] up_addr(input int ch);
        return reg_addr(ADDR_UP_BASE + WB_DATA_W'(8 * ch));
    endfunction

    function automatic logic [WB_DATA_W-1:0] down_addr(input int ch);
        return reg_addr(ADDR_DOWN_BASE + WB_DATA_W'(8 * ch));
    endfunction

    // window rule: high for down-up cycles per frame, empty when down <= up
    task automatic add_row(input int ch, input logic [TIME_W-1:0] up,
            input logic [TIME_W-1:0] down, input logic [TIME_W-1:0] period);
        row_ch[row_count]     = ch;
        row_up[row_count]     = up;
        row_down[row_count]   = down;
        row_period[row_count] = period;
        if (down > up) begin
            row_exp_high[row_count] = down - up;
            row_exp_gap[row_count]  = period;
        end else begin
            row_exp_high[row_count] = '0;
            row_exp_gap[row_count]  = '0;  // never rises
        end
        row_count++;
    endtask

    task automatic random_row(input int ch, input logic [TIME_W-1:0] period);
        logic [TIME_W-1:0] a;
        logic [TIME_W-1:0] b;
        a = TIME_W'((lcg_next() >> 16) % 32'(period));
        b = TIME_W'((lcg_next() >> 16) % 32'(period));
        if (a <= b) begin
            add_row(ch, a, b, period);
        end else begin
            add_row(ch, b, a, period);
        end
    endtask

    task automatic watch_others(input logic [NUM_CH-1:0] own);
        check_word(WB_DATA_W'(strobes & ~own), '0, "strobe of an idle channel");
    endtask

    task automatic wait_strobe(input logic [NUM_CH-1:0] own, input logic level,
            input int limit, input string what);
        int waited;
        waited = 0;
        while ((|(strobes & own)) != level) begin
            @(negedge clk);
            watch_others(own);
            waited++;
            if (waited > limit) begin
                $display("%s within %0d cycles", what, limit);
                abort_run();
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [NUM_CH-1:0] own;
        logic [TIME_W-1:0] high_cycles;
        logic [TIME_W-1:0] gap;
        logic              prev;
        logic              cur;
        logic              done;
        own = NUM_CH'(1) << row_ch[r];
        wb_write(up_addr(row_ch[r]), WB_DATA_W'(row_up[r]), 4'hF);
        wb_write(down_addr(row_ch[r]), WB_DATA_W'(row_down[r]), 4'hF);
        wb_write(reg_addr(ADDR_PERIOD), WB_DATA_W'(row_period[r]), 4'hF);
        repeat (3) @(negedge clk);  // restart passes counter and channel
        if (row_exp_high[r] == '0) begin
            repeat (2 * int'(row_period[r]) + 4) begin
                @(negedge clk);
                check_word(WB_DATA_W'(strobes), '0, "strobe with an empty window");
            end
        end else begin
            wait_strobe(own, 1'b0, int'(row_period[r]) + 2, "strobe did not fall");
            wait_strobe(own, 1'b1, int'(row_period[r]) + 2, "strobe did not rise");
            high_cycles = TIME_W'(1);  // first sample of the frame is high
            gap         = '0;
            prev        = 1'b1;
            done        = 1'b0;
            while (!done) begin
                @(negedge clk);
                watch_others(own);
                gap++;
                cur = |(strobes & own);
                if (cur && !prev) begin
                    done = 1'b1;  // next rising edge
                end else begin
                    high_cycles = high_cycles + TIME_W'(cur);
                    prev        = cur;
                end
                if (!done && gap > row_period[r] + TIME_W'(2)) begin
                    $display("strobe of row %0d did not rise again", r);
                    abort_run();
                end
            end
            check_count(high_cycles, row_exp_high[r], "strobe high cycles per frame");
            check_count(gap, row_exp_gap[r], "spacing of rising edges");
        end
        wb_write(up_addr(row_ch[r]), '0, 4'hF);
        wb_write(down_addr(row_ch[r]), '0, 4'hF);
    endtask

    initial begin
        logic [WB_DATA_W-1:0] rd;
        logic [WB_DATA_W-1:0] wdat;
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_sel   = 4'h0;
        wb_adr   = '0;
        wb_dat_w = '0;

        add_row(CH_VD1, 12'd3, 12'd10, 12'd20);
        add_row(CH_VD2, 12'd0, 12'd5, 12'd16);
        add_row(CH_SW1, 12'd7, 12'd31, 12'd32);
        add_row(CH_SW2, 12'd12, 12'd12, 12'd24);  // down equal to up
        add_row(CH_SH, 12'd15, 12'd4, 12'd30);    // down below up
        random_row(CH_SH_CMP, 12'd40);
        random_row(CH_SH_RST, 12'd48);
        random_row(CH_CNT_RST, 12'd36);
        cycle_limit = SETUP_CYCLES;
        for (int r = 0; r < row_count; r++) begin
            cycle_limit += 3 * int'(row_period[r]) + 50;
        end

        repeat (2) @(negedge clk);
        rst = 1'b0;

        // reset state
        check_word(WB_DATA_W'(wb_ack), '0, "ack after reset");
        for (int ch = 0; ch < NUM_CH; ch++) begin
            wb_read(up_addr(ch), rd);
            check_word(rd, '0, "rise time after reset");
            wb_read(down_addr(ch), rd);
            check_word(rd, '0, "fall time after reset");
        end
        wb_read(reg_addr(ADDR_PERIOD), rd);
        check_word(rd, '0, "period after reset");
        repeat (RESET_WATCH) begin
            @(negedge clk);
            check_word(WB_DATA_W'(strobes), '0, "strobe after reset");
        end

        // read-back, upper bits dropped
        for (int ch = 0; ch < NUM_CH; ch++) begin
            wdat = lcg_next();
            wb_write(up_addr(ch), wdat, 4'hF);
            wb_read(up_addr(ch), rd);
            check_word(rd, wdat & TIME_MASK, "rise time read-back");
            wdat = lcg_next();
            wb_write(down_addr(ch), wdat, 4'hF);
            wb_read(down_addr(ch), rd);
            check_word(rd, wdat & TIME_MASK, "fall time read-back");
        end
        wdat = lcg_next();
        wb_write(reg_addr(ADDR_PERIOD), wdat, 4'hF);
        wb_read(reg_addr(ADDR_PERIOD), rd);
        check_word(rd, wdat & TIME_MASK, "period read-back");

        // lane 0 off means no write
        wb_write(up_addr(CH_SH), 32'h0000_0123, 4'hF);
        wb_write(up_addr(CH_SH), 32'h0000_0456, 4'b1110);
        wb_read(up_addr(CH_SH), rd);
        check_word(rd, 32'h0000_0123, "rise time after write with sel[0] low");
        wb_write(reg_addr(ADDR_PERIOD), 32'h0000_0abc, 4'b0110);
        wb_read(reg_addr(ADDR_PERIOD), rd);
        check_word(rd, wdat & TIME_MASK, "period after write with sel[0] low");

        // unmapped offsets inside the region
        wb_write(reg_addr(32'h44), 32'hffff_ffff, 4'hF);
        wb_read(reg_addr(32'h44), rd);
        check_word(rd, '0, "unmapped offset 0x44");
        wb_read(reg_addr(32'h100), rd);
        check_word(rd, '0, "unmapped offset 0x100");
        wb_read(reg_addr(32'h2), rd);
        check_word(rd, '0, "unaligned offset 0x2");

        for (int ch = 0; ch < NUM_CH; ch++) begin
            wb_write(up_addr(ch), '0, 4'hF);
            wb_write(down_addr(ch), '0, 4'hF);
        end

        for (int r = 0; r < row_count; r++) begin
            run_row(r);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== logic/rlbp_timing_top.sv ====
`timescale 1ns/1ps
// rlbp programmable timing core
// wishbone register bank, frame counter and eight strobe channels

module rlbp_timing_top
    import rlbp_pkg::*;
#(
    parameter int TIME_W = TIME_W_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,

    // wishbone slave
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_we_i,
    input  logic [3:0]           wbs_sel_i,
    input  logic [WB_DATA_W-1:0] wbs_adr_i,
    input  logic [WB_DATA_W-1:0] wbs_dat_i,
    output logic                 wbs_ack_o,
    output logic [WB_DATA_W-1:0] wbs_dat_o,

    // analog control strobes
    output logic                 vd1_o,
    output logic                 vd2_o,
    output logic                 sw1_o,
    output logic                 sw2_o,
    output logic                 sh_o,
    output logic                 sh_cmp_o,
    output logic                 sh_rst_o,
    output logic                 counter_rst_o
);

    logic [NUM_CH-1:0][TIME_W-1:0] time_up;
    logic [NUM_CH-1:0][TIME_W-1:0] time_down;
    logic [TIME_W-1:0]             period;
    logic                          restart;
    logic [TIME_W-1:0]             count;
    logic [NUM_CH-1:0]             strobe;

    rlbp_wb_regs #(
        .TIME_W (TIME_W)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .time_up_o   (time_up),
        .time_down_o (time_down),
        .period_o    (period),
        .restart_o   (restart)
    );

    rlbp_frame_counter #(
        .TIME_W (TIME_W)
    ) u_counter (
        .clk       (clk),
        .rst       (rst),
        .restart_i (restart),
        .period_i  (period),
        .count_o   (count)
    );

    // one window comparator per strobe
    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        rlbp_window_channel #(
            .TIME_W (TIME_W)
        ) u_ch (
            .clk         (clk),
            .rst         (rst),
            .count_i     (count),
            .time_up_i   (time_up[ch]),
            .time_down_i (time_down[ch]),
            .strobe_o    (strobe[ch])
        );
    end

    // strobe pins by channel index
    assign vd1_o         = strobe[CH_VD1];
    assign vd2_o         = strobe[CH_VD2];
    assign sw1_o         = strobe[CH_SW1];
    assign sw2_o         = strobe[CH_SW2];
    assign sh_o          = strobe[CH_SH];
    assign sh_cmp_o      = strobe[CH_SH_CMP];
    assign sh_rst_o      = strobe[CH_SH_RST];
    assign counter_rst_o = strobe[CH_CNT_RST];

endmodule

// ==== logic/rlbp_window_channel.sv ====
`timescale 1ns/1ps
// rlbp strobe channel
// drives one strobe high while the frame count sits inside its window

module rlbp_window_channel
    import rlbp_pkg::*;
#(
    parameter int TIME_W = TIME_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [TIME_W-1:0] count_i,
    input  logic [TIME_W-1:0] time_up_i,
    input  logic [TIME_W-1:0] time_down_i,
    output logic              strobe_o
);

    logic after_up;
    logic before_down;
    logic strobe_q;

    assign after_up    = (count_i >= time_up_i);
    assign before_down = (count_i < time_down_i);  // empty window when down <= up

    // registered, lags the count by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= after_up && before_down;
        end
    end

    assign strobe_o = strobe_q;

endmodule

// ==== logic/rlbp_frame_counter.sv ====
`timescale 1ns/1ps
// rlbp frame counter
// free-running timebase from zero to period minus one

module rlbp_frame_counter
    import rlbp_pkg::*;
#(
    parameter int TIME_W = TIME_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              restart_i,
    input  logic [TIME_W-1:0] period_i,
    output logic [TIME_W-1:0] count_o
);

    logic [TIME_W-1:0] count_q;
    logic              frame_end;

    // last count of the frame
    // >= so a count above a shrunken period still wraps
    assign frame_end = (count_q >= period_i - TIME_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (restart_i) begin
            count_q <= '0;  // new period starts a fresh frame
        end else if (period_i == '0) begin
            count_q <= '0;  // counter parked
        end else if (frame_end) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + TIME_W'(1);
        end
    end

    assign count_o = count_q;

endmodule

// ==== logic/rlbp_wb_regs.sv ====
`timescale 1ns/1ps
// rlbp timing register bank
// wishbone slave holding per-channel strobe edges and the frame period

module rlbp_wb_regs
    import rlbp_pkg::*;
#(
    parameter int TIME_W = TIME_W_DEFAULT
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wbs_cyc_i,
    input  logic                           wbs_stb_i,
    input  logic                           wbs_we_i,
    input  logic [3:0]                     wbs_sel_i,
    input  logic [WB_DATA_W-1:0]           wbs_adr_i,
    input  logic [WB_DATA_W-1:0]           wbs_dat_i,
    output logic                           wbs_ack_o,
    output logic [WB_DATA_W-1:0]           wbs_dat_o,
    output logic [NUM_CH-1:0][TIME_W-1:0]  time_up_o,
    output logic [NUM_CH-1:0][TIME_W-1:0]  time_down_o,
    output logic [TIME_W-1:0]              period_o,
    output logic                           restart_o
);

    localparam int OFF_W    = WB_DATA_W - 4;    // offset bits below the region field
    localparam int CH_IDX_W = $clog2(NUM_CH);

    logic [OFF_W-1:0]    offset;
    logic [CH_IDX_W-1:0] ch_sel;
    logic                req_valid;
    logic                wr_en;
    logic                time_hit;
    logic                up_hit;
    logic                down_hit;
    logic                period_hit;
    logic [WB_DATA_W-1:0] rd_word;

    logic [NUM_CH-1:0][TIME_W-1:0] time_up_q;
    logic [NUM_CH-1:0][TIME_W-1:0] time_down_q;
    logic [TIME_W-1:0]             period_q;
    logic                          ack_q;
    logic [WB_DATA_W-1:0]          rdata_q;
    logic                          restart_q;

    // request decode
    assign req_valid = wbs_cyc_i && wbs_stb_i && (wbs_adr_i[31:28] == REGION_ID);
    assign wr_en     = req_valid && wbs_we_i && wbs_sel_i[0];  // only the low byte lane counts

    assign offset = wbs_adr_i[OFF_W-1:0];
    assign ch_sel = offset[CH_IDX_W+2:3];  // 8 bytes per channel

    // word aligned and inside the time register block
    assign time_hit   = (offset < OFF_W'(NUM_CH * 8)) && (offset[1:0] == 2'b00);
    assign up_hit     = time_hit && (offset[2:0] == ADDR_UP_BASE[2:0]);
    assign down_hit   = time_hit && (offset[2:0] == ADDR_DOWN_BASE[2:0]);
    assign period_hit = (offset == ADDR_PERIOD[OFF_W-1:0]);

    // read mux, zero extended, unmapped reads zero
    always_comb begin
        rd_word = '0;
        if (up_hit) begin
            rd_word[TIME_W-1:0] = time_up_q[ch_sel];
        end else if (down_hit) begin
            rd_word[TIME_W-1:0] = time_down_q[ch_sel];
        end else if (period_hit) begin
            rd_word[TIME_W-1:0] = period_q;
        end
    end

    // register writes
    always_ff @(posedge clk) begin
        if (rst) begin
            time_up_q   <= '0;
            time_down_q <= '0;
            period_q    <= '0;
        end else if (wr_en) begin
            if (up_hit) begin
                time_up_q[ch_sel] <= wbs_dat_i[TIME_W-1:0];
            end
            if (down_hit) begin
                time_down_q[ch_sel] <= wbs_dat_i[TIME_W-1:0];
            end
            if (period_hit) begin
                period_q <= wbs_dat_i[TIME_W-1:0];
            end
        end
    end

    // ack and read data go out together, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q <= req_valid;  // no wait states
            if (req_valid) begin
                rdata_q <= rd_word;
            end
        end
    end

    // frame restart on every period write
    always_ff @(posedge clk) begin
        if (rst) begin
            restart_q <= 1'b0;
        end else begin
            restart_q <= wr_en && period_hit;
        end
    end

    assign wbs_ack_o   = ack_q;
    assign wbs_dat_o   = rdata_q;
    assign time_up_o   = time_up_q;
    assign time_down_o = time_down_q;
    assign period_o    = period_q;
    assign restart_o   = restart_q;

endmodule

// ==== logic/rlbp_pkg.sv ====
// rlbp timing core shared constants
// bus widths, register map and strobe channel order

package rlbp_pkg;

    // bus and datapath widths
    localparam int WB_DATA_W      = 32;
    localparam int TIME_W_DEFAULT = 12;  // time and period values
    localparam int NUM_CH         = 8;   // analog control strobes

    // adr[31:28] selects this macro
    localparam logic [3:0] REGION_ID = 4'd3;

    // register map, byte offsets inside the region
    // rise of channel n at 8n, fall of channel n at 8n+4
    localparam logic [WB_DATA_W-1:0] ADDR_UP_BASE   = 32'd0;
    localparam logic [WB_DATA_W-1:0] ADDR_DOWN_BASE = 32'd4;
    localparam logic [WB_DATA_W-1:0] ADDR_PERIOD    = 32'd64;  // frame period

    // strobe channel indices
    localparam int CH_VD1     = 0;
    localparam int CH_VD2     = 1;
    localparam int CH_SW1     = 2;
    localparam int CH_SW2     = 3;
    localparam int CH_SH      = 4;
    localparam int CH_SH_CMP  = 5;
    localparam int CH_SH_RST  = 6;
    localparam int CH_CNT_RST = 7;  // counter reset strobe

endpackage
